// File: design/corePkg.sv
// Shared widths, encodings and stage bundles of the five-stage core
// Word accesses only, byte and halfword forms are not decoded
package corePkg;

  localparam int Xlen = 32;                  // Data width

  typedef logic [Xlen-1:0] wordT;            // Data and address
  typedef logic [4:0]      regIdxT;          // Register index

  localparam wordT ResetPc  = '0;            // First fetch address
  localparam wordT NopInstr = 32'h0000_0013; // ADDI x0,x0,0

  // Major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    I_OP   = 7'b0010011,
    R_OP   = 7'b0110011,
    FENCE  = 7'b0001111   // Decoded as a no-op
  } opcodeT;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } aluOpT;

  typedef enum logic [2:0] {
    I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
  } immTypeT;

  // Follows funct3 of the branch opcode
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branchTypeT;

  //////////////////////////////////////////////////////////////////////
  // Stage bundles
  //////////////////////////////////////////////////////////////////////

  // Q102H, decode to execute
  typedef struct packed {
    wordT       pc;
    wordT       pcPlus4;
    wordT       imm;
    regIdxT     rs1;
    regIdxT     rs2;
    regIdxT     rd;
    wordT       rs1Data;
    wordT       rs2Data;
    aluOpT      aluOp;
    branchTypeT branchOp;
    logic       isJump;      // JAL or JALR
    logic       isBranch;
    logic       isLui;
    logic       isLoad;
    logic       isStore;
    logic       aluSelPc;    // ALU input 1 from PC
    logic       aluSelImm;   // ALU input 2 from immediate
    logic       regWrEn;     // Never set for rd x0
  } idExT;

  // Q103H, execute to memory
  typedef struct packed {
    wordT   aluOut;
    wordT   storeData;
    wordT   pcPlus4;
    regIdxT rd;
    logic   isLoad;
    logic   isStore;
    logic   linkWr;          // Write PC+4 back
    logic   regWrEn;
  } exMemT;

  // Q104H register write
  typedef struct packed {
    regIdxT rd;
    wordT   data;
    logic   wrEn;
  } wrBackT;

endpackage

// File: design/fetchStage.sv
// PC and the Q100H to Q101H registers
// A taken branch or jump overrides the enable from the hazard logic never
`timescale 1ns/1ps

module fetchStage
  import corePkg::*;
(
  input  logic Clock,
  input  logic rstN,
  input  logic pcEn,          // Low for one cycle on a load-use stall
  input  logic takeQ102H,     // Taken branch or jump in execute
  input  wordT targetQ102H,
  output wordT pcQ100H,       // To instruction memory
  output wordT pcQ101H,
  output wordT pcPlus4Q101H
);

  wordT pcPlus4Q100H;
  wordT nextPcQ100H;

  assign pcPlus4Q100H = pcQ100H + wordT'(4);
  assign nextPcQ100H  = takeQ102H ? targetQ102H : pcPlus4Q100H;  // Redirect or sequential

  // Program counter
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      pcQ100H <= ResetPc;
    end else if (pcEn) begin
      pcQ100H <= nextPcQ100H;
    end
  end

  // Q101H copies, held together with the PC
  always_ff @(posedge Clock) begin
    if (pcEn) begin
      pcQ101H      <= pcQ100H;
      pcPlus4Q101H <= pcPlus4Q100H;
    end
  end

endmodule

// File: design/decodeStage.sv
// Decode, load-use stall and flush; instruction arrives one cycle after its PC
// FENCE and unknown opcodes decode as no-ops with no register write
`timescale 1ns/1ps

module decodeStage
  import corePkg::*;
(
  input  logic   Clock,
  input  logic   rstN,
  input  wordT   instrQ101H,    // From instruction memory
  input  wordT   pcQ101H,
  input  wordT   pcPlus4Q101H,
  input  logic   flushQ102H,    // Taken jump now in execute
  input  logic   flushQ103H,    // Same, one cycle later
  input  wordT   rs1Data,       // From regFile, bypassed
  input  wordT   rs2Data,
  output logic   pcEn,
  output regIdxT rs1,
  output regIdxT rs2,
  output idExT   idExQ102H
);

  logic    validQ101H;          // Low in the first cycle after reset
  logic    loadHzrdQ101H;
  logic    loadHzrdQ102H;
  wordT    prevInstrQ101H;      // Held copy for replay
  wordT    instr;
  opcodeT  opcode;
  logic    [2:0] funct3;
  logic    [6:0] funct7;
  regIdxT  rd;
  aluOpT   aluOp;
  immTypeT immType;
  wordT    imm;
  idExT    idExQ101H;

  //////////////////////////////////////////////////////////////////////
  // Hazard and instruction select
  //////////////////////////////////////////////////////////////////////

  // Load in execute feeds a source of the incoming instruction
  assign loadHzrdQ101H = validQ101H && idExQ102H.isLoad && (idExQ102H.rd != '0) &&
                         ((instrQ101H[19:15] == idExQ102H.rd) ||
                          (instrQ101H[24:20] == idExQ102H.rd));
  assign pcEn = !loadHzrdQ101H;

  always_comb begin
    if (flushQ102H || flushQ103H || !validQ101H || loadHzrdQ101H) begin
      instr = NopInstr;                       // Bubble
    end else if (loadHzrdQ102H) begin
      instr = prevInstrQ101H;                 // Replay the stalled one
    end else begin
      instr = instrQ101H;
    end
  end

  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      validQ101H    <= 1'b0;
      loadHzrdQ102H <= 1'b0;
    end else begin
      validQ101H    <= 1'b1;
      loadHzrdQ102H <= loadHzrdQ101H;
    end
  end

  always_ff @(posedge Clock) begin
    prevInstrQ101H <= instrQ101H;
  end

  //////////////////////////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////////////////////////

  assign opcode = opcodeT'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  always_comb begin
    aluOp = ADD;                              // Address and target adds
    if ((opcode == R_OP) || (opcode == I_OP)) begin
      case (funct3)
        3'b000:  aluOp = ((opcode == R_OP) && funct7[5]) ? SUB : ADD;
        3'b001:  aluOp = SLL;
        3'b010:  aluOp = SLT;
        3'b011:  aluOp = SLTU;
        3'b100:  aluOp = XOR;
        3'b101:  aluOp = funct7[5] ? SRA : SRL;
        3'b110:  aluOp = OR;
        default: aluOp = AND;
      endcase
    end
  end

  // Immediate generator
  always_comb begin
    unique case (opcode)
      LUI, AUIPC: immType = U_TYPE;
      JAL:        immType = J_TYPE;
      BRANCH:     immType = B_TYPE;
      STORE:      immType = S_TYPE;
      default:    immType = I_TYPE;
    endcase
    unique case (immType)
      U_TYPE:  imm = {instr[31:12], 12'b0};
      J_TYPE:  imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      B_TYPE:  imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      S_TYPE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      default: imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  always_comb begin
    idExQ101H           = '0;
    idExQ101H.pc        = pcQ101H;
    idExQ101H.pcPlus4   = pcPlus4Q101H;
    idExQ101H.imm       = imm;
    idExQ101H.rs1       = rs1;
    idExQ101H.rs2       = rs2;
    idExQ101H.rd        = rd;
    idExQ101H.rs1Data   = rs1Data;
    idExQ101H.rs2Data   = rs2Data;
    idExQ101H.aluOp     = aluOp;
    idExQ101H.branchOp  = branchTypeT'(funct3);
    idExQ101H.isJump    = (opcode == JAL) || (opcode == JALR);
    idExQ101H.isBranch  = (opcode == BRANCH);
    idExQ101H.isLui     = (opcode == LUI);
    idExQ101H.isLoad    = (opcode == LOAD);
    idExQ101H.isStore   = (opcode == STORE);
    idExQ101H.aluSelPc  = (opcode == JAL) || (opcode == BRANCH) || (opcode == AUIPC);
    idExQ101H.aluSelImm = (opcode != R_OP);
    idExQ101H.regWrEn   = (rd != '0) &&       // x0 writes dropped here
                          ((opcode == LUI)  || (opcode == AUIPC) || (opcode == JAL) ||
                           (opcode == JALR) || (opcode == LOAD)  || (opcode == I_OP) ||
                           (opcode == R_OP));
  end

  // Q101H to Q102H
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      idExQ102H <= '0;
    end else begin
      idExQ102H <= idExQ101H;
    end
  end

  // Bubble clears the load flag so the stall lasts one cycle
  assert property (@(posedge Clock) disable iff (!rstN) loadHzrdQ101H |=> !loadHzrdQ101H);

endmodule

// File: design/regFile.sv
// x1 to x31 with x0 tied to zero; no reset on the storage
// Reads are combinational and see the Q104H write of the same cycle
`timescale 1ns/1ps

module regFile
  import corePkg::*;
(
  input  logic   Clock,
  input  logic   rstN,
  input  regIdxT rs1,
  input  regIdxT rs2,
  input  wrBackT wrBack,     // Q104H write port
  output wordT   rs1Data,
  output wordT   rs2Data
);

  wordT regs [1:31];

  always_ff @(posedge Clock) begin
    if (wrBack.wrEn && (wrBack.rd != '0)) begin
      regs[wrBack.rd] <= wrBack.data;
    end
  end

  // Zero for x0, bypass on a matching write
  function automatic wordT readReg(regIdxT idx);
    if (idx == '0) begin
      return '0;
    end else if (wrBack.wrEn && (wrBack.rd == idx)) begin
      return wrBack.data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1Data = readReg(rs1);
    rs2Data = readReg(rs2);
  end

  // Decode never lets an x0 write reach write-back
  assert property (@(posedge Clock) disable iff (!rstN) wrBack.wrEn |-> (wrBack.rd != '0));

endmodule

// File: design/executeStage.sv
// Execute with Q103H/Q104H forwarding, ALU and branch resolve
// A load result is never forwarded from Q103H; decode stalls for it
`timescale 1ns/1ps

module executeStage
  import corePkg::*;
(
  input  logic   Clock,
  input  logic   rstN,
  input  idExT   idExQ102H,
  input  wordT   aluOutQ103H,     // Forward source one stage ahead
  input  regIdxT rdQ103H,
  input  logic   regWrEnQ103H,
  input  wrBackT wrBack,          // Forward source two stages ahead
  output logic   takeQ102H,
  output wordT   targetQ102H,
  output logic   flushQ103H,
  output exMemT  exMemQ103H
);

  wordT       opAQ102H;           // Forwarded rs1
  wordT       opBQ102H;           // Forwarded rs2
  wordT       aluIn1Q102H;
  wordT       aluIn2Q102H;
  wordT       aluOutQ102H;
  logic [4:0] shamtQ102H;
  logic       condMetQ102H;
  exMemT      exMemQ102H;

  // Newest producer wins; x0 is never forwarded
  function automatic wordT fwdOperand(regIdxT src, wordT regData);
    if (src == '0) begin
      return regData;
    end else if (regWrEnQ103H && (rdQ103H == src)) begin
      return aluOutQ103H;
    end else if (wrBack.wrEn && (wrBack.rd == src)) begin
      return wrBack.data;
    end
    return regData;
  endfunction

  always_comb begin
    opAQ102H = fwdOperand(idExQ102H.rs1, idExQ102H.rs1Data);
    opBQ102H = fwdOperand(idExQ102H.rs2, idExQ102H.rs2Data);
  end

  assign aluIn1Q102H = idExQ102H.aluSelPc  ? idExQ102H.pc  : opAQ102H;
  assign aluIn2Q102H = idExQ102H.aluSelImm ? idExQ102H.imm : opBQ102H;
  assign shamtQ102H  = aluIn2Q102H[4:0];

  //////////////////////////////////////////////////////////////////////
  // ALU and branch compare
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (idExQ102H.aluOp)
      SUB:     aluOutQ102H = aluIn1Q102H - aluIn2Q102H;
      SLL:     aluOutQ102H = aluIn1Q102H << shamtQ102H;
      SLT:     aluOutQ102H = {{(Xlen-1){1'b0}}, $signed(aluIn1Q102H) < $signed(aluIn2Q102H)};
      SLTU:    aluOutQ102H = {{(Xlen-1){1'b0}}, aluIn1Q102H < aluIn2Q102H};
      XOR:     aluOutQ102H = aluIn1Q102H ^ aluIn2Q102H;
      SRL:     aluOutQ102H = aluIn1Q102H >> shamtQ102H;
      SRA:     aluOutQ102H = $signed(aluIn1Q102H) >>> shamtQ102H;
      OR:      aluOutQ102H = aluIn1Q102H | aluIn2Q102H;
      AND:     aluOutQ102H = aluIn1Q102H & aluIn2Q102H;
      default: aluOutQ102H = aluIn1Q102H + aluIn2Q102H;   // ADD, addresses, targets
    endcase
    if (idExQ102H.isLui) begin
      aluOutQ102H = aluIn2Q102H;                           // Immediate straight through
    end
  end

  always_comb begin
    unique case (idExQ102H.branchOp)
      BEQ:     condMetQ102H = (opAQ102H == opBQ102H);
      BNE:     condMetQ102H = (opAQ102H != opBQ102H);
      BLT:     condMetQ102H = ($signed(opAQ102H) <  $signed(opBQ102H));
      BGE:     condMetQ102H = ($signed(opAQ102H) >= $signed(opBQ102H));
      BLTU:    condMetQ102H = (opAQ102H <  opBQ102H);
      BGEU:    condMetQ102H = (opAQ102H >= opBQ102H);
      default: condMetQ102H = 1'b0;
    endcase
  end

  // Next PC; bit 0 cleared for JALR
  assign takeQ102H   = idExQ102H.isJump || (idExQ102H.isBranch && condMetQ102H);
  assign targetQ102H = {aluOutQ102H[Xlen-1:1], 1'b0};

  always_comb begin
    exMemQ102H.aluOut    = aluOutQ102H;
    exMemQ102H.storeData = opBQ102H;
    exMemQ102H.pcPlus4   = idExQ102H.pcPlus4;
    exMemQ102H.rd        = idExQ102H.rd;
    exMemQ102H.isLoad    = idExQ102H.isLoad;
    exMemQ102H.isStore   = idExQ102H.isStore;
    exMemQ102H.linkWr    = idExQ102H.isJump;      // Both jumps link
    exMemQ102H.regWrEn   = idExQ102H.regWrEn;
  end

  // Q102H to Q103H, flush goes along
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      exMemQ103H <= '0;
      flushQ103H <= 1'b0;
    end else begin
      exMemQ103H <= exMemQ102H;
      flushQ103H <= takeQ102H;
    end
  end

endmodule

// File: design/memWbStage.sv
// Data-memory port and write-back select, word accesses only
// Read data is expected aligned in the cycle after the read enable
`timescale 1ns/1ps

module memWbStage
  import corePkg::*;
(
  input  logic   Clock,
  input  logic   rstN,
  input  exMemT  exMemQ103H,
  input  wordT   dMemRdDataQ104H,   // From data memory
  output wordT   dMemAddrQ103H,
  output wordT   dMemWrDataQ103H,
  output logic   dMemWrEnQ103H,
  output logic   dMemRdEnQ103H,
  output wrBackT wrBack
);

  wordT   aluOutQ104H;
  wordT   pcPlus4Q104H;
  regIdxT rdQ104H;
  logic   isLoadQ104H;
  logic   linkWrQ104H;
  logic   regWrEnQ104H;

  assign dMemAddrQ103H   = exMemQ103H.aluOut;
  assign dMemWrDataQ103H = exMemQ103H.storeData;
  assign dMemWrEnQ103H   = exMemQ103H.isStore;
  assign dMemRdEnQ103H   = exMemQ103H.isLoad;

  // Q103H to Q104H control
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      isLoadQ104H  <= 1'b0;
      linkWrQ104H  <= 1'b0;
      regWrEnQ104H <= 1'b0;
    end else begin
      isLoadQ104H  <= exMemQ103H.isLoad;
      linkWrQ104H  <= exMemQ103H.linkWr;
      regWrEnQ104H <= exMemQ103H.regWrEn;
    end
  end

  always_ff @(posedge Clock) begin
    aluOutQ104H  <= exMemQ103H.aluOut;
    pcPlus4Q104H <= exMemQ103H.pcPlus4;
    rdQ104H      <= exMemQ103H.rd;
  end

  // Link, load, else ALU
  assign wrBack.rd   = rdQ104H;
  assign wrBack.wrEn = regWrEnQ104H;
  assign wrBack.data = linkWrQ104H ? pcPlus4Q104H    :
                       isLoadQ104H ? dMemRdDataQ104H :
                                     aluOutQ104H;

  // One opcode per slot, so never both
  assert property (@(posedge Clock) disable iff (!rstN) !(dMemWrEnQ103H && dMemRdEnQ103H));

endmodule

// File: design/miniCore.sv
// Five-stage RV32I core top; memories sit outside with fixed latency
// No back-pressure, the core assumes every access completes on schedule
`timescale 1ns/1ps

module miniCore
  import corePkg::*;
(
  input  logic Clock,
  input  logic rstN,
  // Instruction memory
  output wordT pcQ100H,
  input  wordT instrQ101H,
  // Data memory
  output wordT dMemAddrQ103H,
  output wordT dMemWrDataQ103H,
  output logic dMemWrEnQ103H,
  output logic dMemRdEnQ103H,
  input  wordT dMemRdDataQ104H
);

  logic   pcEn;
  logic   takeQ102H;
  logic   flushQ103H;
  wordT   targetQ102H;
  wordT   pcQ101H;
  wordT   pcPlus4Q101H;
  regIdxT rs1;
  regIdxT rs2;
  wordT   rs1Data;
  wordT   rs2Data;
  idExT   idExQ102H;
  exMemT  exMemQ103H;
  wrBackT wrBack;

  fetchStage fetch (
    .Clock        (Clock),
    .rstN         (rstN),
    .pcEn         (pcEn),
    .takeQ102H    (takeQ102H),
    .targetQ102H  (targetQ102H),
    .pcQ100H      (pcQ100H),
    .pcQ101H      (pcQ101H),
    .pcPlus4Q101H (pcPlus4Q101H)
  );

  decodeStage decode (
    .Clock        (Clock),
    .rstN         (rstN),
    .instrQ101H   (instrQ101H),
    .pcQ101H      (pcQ101H),
    .pcPlus4Q101H (pcPlus4Q101H),
    .flushQ102H   (takeQ102H),       // Redirect in execute
    .flushQ103H   (flushQ103H),
    .rs1Data      (rs1Data),
    .rs2Data      (rs2Data),
    .pcEn         (pcEn),
    .rs1          (rs1),
    .rs2          (rs2),
    .idExQ102H    (idExQ102H)
  );

  regFile regs (
    .Clock   (Clock),
    .rstN    (rstN),
    .rs1     (rs1),
    .rs2     (rs2),
    .wrBack  (wrBack),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data)
  );

  executeStage execute (
    .Clock        (Clock),
    .rstN         (rstN),
    .idExQ102H    (idExQ102H),
    .aluOutQ103H  (dMemAddrQ103H),   // Q103H ALU result doubles as address
    .rdQ103H      (exMemQ103H.rd),
    .regWrEnQ103H (exMemQ103H.regWrEn),
    .wrBack       (wrBack),
    .takeQ102H    (takeQ102H),
    .targetQ102H  (targetQ102H),
    .flushQ103H   (flushQ103H),
    .exMemQ103H   (exMemQ103H)
  );

  memWbStage memWb (
    .Clock           (Clock),
    .rstN            (rstN),
    .exMemQ103H      (exMemQ103H),
    .dMemRdDataQ104H (dMemRdDataQ104H),
    .dMemAddrQ103H   (dMemAddrQ103H),
    .dMemWrDataQ103H (dMemWrDataQ103H),
    .dMemWrEnQ103H   (dMemWrEnQ103H),
    .dMemRdEnQ103H   (dMemRdEnQ103H),
    .wrBack          (wrBack)
  );

endmodule

// File: verification/miniCoreTb.sv
// Testbench for miniCore; program, data and expected stores come from the golden file
// Memories are 256 words each, so programs stay below byte address 0x400
`timescale 1ns/1ps

module miniCoreTb
  import corePkg::*;
();

  localparam int ResetCycles  = 16;
  localparam int StoreTimeout = 400;   // Cycles allowed per expected store
  localparam int DrainCycles  = 40;    // Quiet time for extra stores

  logic Clock;
  logic rstN;
  wordT pcQ100H;
  wordT instrQ101H;
  wordT dMemAddrQ103H;
  wordT dMemWrDataQ103H;
  logic dMemWrEnQ103H;
  logic dMemRdEnQ103H;
  wordT dMemRdDataQ104H;

  wordT iMem [0:255];
  wordT dMem [0:255];
  wordT iAddrQ;                        // PC seen at the last rising edge
  wordT rdAddrQ;
  wordT expAddr [$];
  wordT expData [$];
  wordT gotAddr [$];
  wordT gotData [$];
  int   addrErrors;
  int   dataErrors;
  int   enableErrors;
  int   otherErrors;

  miniCore dut (
    .Clock           (Clock),
    .rstN            (rstN),
    .pcQ100H         (pcQ100H),
    .instrQ101H      (instrQ101H),
    .dMemAddrQ103H   (dMemAddrQ103H),
    .dMemWrDataQ103H (dMemWrDataQ103H),
    .dMemWrEnQ103H   (dMemWrEnQ103H),
    .dMemRdEnQ103H   (dMemRdEnQ103H),
    .dMemRdDataQ104H (dMemRdDataQ104H)
  );

  always #2 Clock = ~Clock;            // 4 ns period

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic checkAddr(input string name, input wordT got, input wordT exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      addrErrors++;
    end
  endtask

  task automatic checkData(input string name, input wordT got, input wordT exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      dataErrors++;
    end
  endtask

  task automatic checkEnable(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      enableErrors++;
    end
  endtask

  // Lines are P (program), D (initial data) or S (expected store), then address and value
  task automatic loadGolden();
    int fd;
    byte kind;
    wordT addr;
    wordT value;
    logic [8*120-1:0] skipBuf;
    fd = $fopen("verification/miniCoreGolden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file");
      otherErrors++;
      return;
    end
    while ($fscanf(fd, " %c", kind) == 1) begin
      if (kind == "#") begin
        void'($fgets(skipBuf, fd));     // Comment line
      end else if ($fscanf(fd, "%h %h", addr, value) != 2) begin
        $display("Golden file line of kind %c is malformed", kind);
        otherErrors++;
      end else if (kind == "P") begin
        iMem[addr[9:2]] = value;
      end else if (kind == "D") begin
        dMem[addr[9:2]] = value;
      end else if (kind == "S") begin
        expAddr.push_back(addr);
        expData.push_back(value);
      end else begin
        $display("Golden file has an unknown line kind %c", kind);
        otherErrors++;
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory models
  //////////////////////////////////////////////////////////////////////

  // One cycle latency, driven on the falling edge
  always @(posedge Clock) iAddrQ <= pcQ100H;
  always @(negedge Clock) instrQ101H <= iMem[iAddrQ[9:2]];

  always @(posedge Clock) begin
    if (!rstN) begin
      // Both enables quiet under reset
      checkEnable("dMemWrEnQ103H", dMemWrEnQ103H, 1'b0);
      checkEnable("dMemRdEnQ103H", dMemRdEnQ103H, 1'b0);
    end else if (dMemWrEnQ103H) begin
      dMem[dMemAddrQ103H[9:2]] = dMemWrDataQ103H;
      gotAddr.push_back(dMemAddrQ103H);
      gotData.push_back(dMemWrDataQ103H);
    end
    if (dMemRdEnQ103H) begin
      rdAddrQ <= dMemAddrQ103H;
    end
  end

  always @(negedge Clock) dMemRdDataQ104H <= dMem[rdAddrQ[9:2]];   // Word aligned only

  initial begin
    int unsigned seed;
    int cycles;
    seed = 32'haac;
    Clock = 1'b0;
    rstN = 1'b0;
    instrQ101H = NopInstr;
    dMemRdDataQ104H = '0;
    iAddrQ = ResetPc;
    rdAddrQ = '0;
    addrErrors = 0;
    dataErrors = 0;
    enableErrors = 0;
    otherErrors = 0;
    void'($urandom(seed));
    for (int i = 0; i < 256; i++) begin
      iMem[i] = NopInstr | wordT'(i << 20);    // ADDI x0,x0,i
      dMem[i] = $urandom() ^ wordT'(i << 2);   // Never read by the programs
    end
    loadGolden();

    // Reset for 16 cycles, released on a falling edge
    repeat (ResetCycles) @(negedge Clock);
    rstN = 1'b1;
    checkAddr("pcQ100H", pcQ100H, ResetPc);    // First fetch, no rising edge since release

    for (int i = 0; i < expAddr.size(); i++) begin
      cycles = 0;
      while (gotAddr.size() <= i && cycles < StoreTimeout) begin
        @(negedge Clock);
        cycles++;
      end
      if (gotAddr.size() <= i) begin
        $display("Timed out waiting for store %0d", i);
        otherErrors++;
        break;
      end
      checkAddr($sformatf("dMemAddrQ103H store %0d", i), gotAddr[i], expAddr[i]);
      checkData($sformatf("dMemWrDataQ103H store %0d", i), gotData[i], expData[i]);
    end

    repeat (DrainCycles) @(negedge Clock);
    if (gotAddr.size() > expAddr.size()) begin
      $display("Saw %0d stores but expected only %0d", gotAddr.size(), expAddr.size());
      otherErrors++;
    end

    $display("Errors: addr=%0d data=%0d enable=%0d other=%0d",
             addrErrors, dataErrors, enableErrors, otherErrors);
    if (addrErrors + dataErrors + enableErrors + otherErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: miniCore.f
design/corePkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/regFile.sv
design/executeStage.sv
design/memWbStage.sv
design/miniCore.sv
verification/miniCoreTb.sv

// File: verification/miniCoreGolden.txt
# P addr instr = program word, D addr value = initial data word
# S addr value = expected store, in program order
P 000 123450B7
P 004 FF900113
P 008 00500193
P 00C 00310233
P 010 403102B3
P 014 00319333
P 018 003123B3
P 01C 00313433
P 020 003144B3
P 024 00315533
P 028 403155B3
P 02C 00316633
P 030 003176B3
P 034 10102023
P 038 10402223
P 03C 10502423
P 040 10602623
P 044 10702823
P 048 10802A23
P 04C 10902C23
P 050 10A02E23
P 054 12B02023
P 058 12C02223
P 05C 12D02423
P 060 06410713
P 064 FFF12793
P 068 FFF13813
P 06C 0F014893
P 070 7001E913
P 074 07F17993
P 078 01C19A13
P 07C 01C15A93
P 080 40C0DB13
P 084 12E02623
P 088 12F02823
P 08C 13002A23
P 090 13102C23
P 094 13202E23
P 098 15302023
P 09C 15402223
P 0A0 15502423
P 0A4 15602623
P 0A8 00001B97
P 0AC 15702823
P 0B0 03700013
P 0B4 00900C13
P 0B8 00100C93
P 0BC 00200D13
P 0C0 000C0DB3
P 0C4 15B02A23
P 0C8 20002E03
P 0CC 019E0EB3
P 0D0 15D02C23
P 0D4 00000F93
P 0D8 019C8463
P 0DC 001F8F93
P 0E0 01AC8463
P 0E4 002F8F93
P 0E8 01AC9463
P 0EC 004F8F93
P 0F0 019C9463
P 0F4 008F8F93
P 0F8 00314463
P 0FC 010F8F93
P 100 0021C463
P 104 020F8F93
P 108 0021D463
P 10C 040F8F93
P 110 00315463
P 114 080F8F93
P 118 0021E463
P 11C 100F8F93
P 120 00316463
P 124 200F8F93
P 128 00317463
P 12C 400F8F93
P 130 0021F463
P 134 800F8F93
P 138 15F02E23
P 13C 00C002EF
P 140 001F8F93
P 144 002F8F93
P 148 16502023
P 14C 15D00313
P 150 000303E7
P 154 004F8F93
P 158 008F8F93
P 15C 16702223
P 160 17F02423
P 164 0000006F
D 200 00ABCDEF
S 100 12345000
S 104 FFFFFFFE
S 108 FFFFFFF4
S 10C 000000A0
S 110 00000001
S 114 00000000
S 118 FFFFFFFC
S 11C 07FFFFFF
S 120 FFFFFFFF
S 124 FFFFFFFD
S 128 00000001
S 12C 0000005D
S 130 00000001
S 134 00000001
S 138 FFFFFF09
S 13C 00000705
S 140 00000079
S 144 50000000
S 148 0000000F
S 14C 00012345
S 150 000010A8
S 154 00000009
S 158 00ABCDF0
S 15C FFFFFAAA
S 160 00000140
S 164 00000154
S 168 FFFFFAAA
